//--- Bender.yml
package:
  name: dcache

sources:
  - cache_pkg.sv
  - tag_match.sv
  - plru_tree.sv
  - cache_mem.sv
  - victim_buffer.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_dcache.sv

//--- cache_mem.sv
// set-associative line array with read lookup, write forwarding, install and victim output
module cache_mem import cache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd_en,
  input  logic [set_bits-1:0]  rd_set,
  input  logic [tag_bits-1:0]  rd_tag,
  input  logic                 wr_en,
  input  logic [set_bits-1:0]  wr_set,
  input  logic [tag_bits-1:0]  wr_tag,
  input  logic [data_bits-1:0] wr_data,
  input  logic                 wr_dirty,
  output logic                 cm_rd_hit,
  output logic [data_bits-1:0] cm_rd_data,
  output logic                 wr_miss,
  output logic                 evict_valid,
  output logic [addr_bits-1:0] evict_addr,
  output logic [data_bits-1:0] evict_data,
  output logic                 evict_dirty
);

  logic [num_ways-1:0][data_bits-1:0] line_data [num_sets];
  logic [num_ways-1:0][tag_bits-1:0]  line_tag [num_sets];
  logic [num_ways-1:0]                line_valid [num_sets];
  logic [num_ways-1:0]                line_dirty [num_sets];

  logic                rd_array_hit;
  logic [way_bits-1:0] rd_array_way;
  logic                rd_fwd;
  logic                wr_hit;
  logic [way_bits-1:0] wr_hit_way;
  logic [way_bits-1:0] victim_way;
  logic [way_bits-1:0] wr_way;

  tag_match u_rd_match (
    .way_tags  (line_tag[rd_set]),
    .way_valid (line_valid[rd_set]),
    .tag       (rd_tag),
    .hit       (rd_array_hit),
    .way       (rd_array_way)
  );

  tag_match u_wr_match (
    .way_tags  (line_tag[wr_set]),
    .way_valid (line_valid[wr_set]),
    .tag       (wr_tag),
    .hit       (wr_hit),
    .way       (wr_hit_way)
  );

  plru_tree u_plru_tree (
    .clock      (clock),
    .reset      (reset),
    .rd_touch   (rd_en && rd_array_hit),
    .rd_set     (rd_set),
    .rd_way     (rd_array_way),
    .wr_touch   (wr_en),
    .wr_set     (wr_set),
    .wr_way     (wr_way),
    .victim_set (wr_set),
    .victim_way (victim_way)
  );

  // same-cycle write to the same line
  assign rd_fwd = rd_en && wr_en && (rd_set == wr_set) && (rd_tag == wr_tag);

  assign cm_rd_hit = rd_fwd || (rd_en && rd_array_hit);

  always_comb begin
    if (rd_fwd) begin
      cm_rd_data = wr_data;
    end else if (rd_en && rd_array_hit) begin
      cm_rd_data = line_data[rd_set][rd_array_way];
    end else begin
      cm_rd_data = '0;
    end
  end

  // hit updates in place, miss takes the PLRU victim
  assign wr_miss = wr_en && !wr_hit;
  assign wr_way = wr_hit ? wr_hit_way : victim_way;

  // old line leaves only if it held something
  assign evict_valid = wr_miss && line_valid[wr_set][victim_way];
  assign evict_addr = {line_tag[wr_set][victim_way], wr_set};
  assign evict_data = line_data[wr_set][victim_way];
  assign evict_dirty = line_dirty[wr_set][victim_way];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        line_valid[s] <= '0;
        line_dirty[s] <= '0;
      end
    end else if (wr_en) begin
      line_valid[wr_set][wr_way] <= 1'b1;
      line_dirty[wr_set][wr_way] <= wr_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_data[wr_set][wr_way] <= wr_data;
      line_tag[wr_set][wr_way] <= wr_tag;
    end
  end

endmodule

//--- cache_pkg.sv
// data cache geometry constants shared by all blocks
package cache_pkg;

  // ways per set
  localparam int num_ways = 4;

  // number of sets
  localparam int num_sets = 8;

  // set index width
  localparam int set_bits = 3;

  // tag width
  localparam int tag_bits = 10;

  // line address, tag in the upper bits and set in the low bits
  localparam int addr_bits = set_bits + tag_bits;

  // line payload width
  localparam int data_bits = 64;

  // way index width
  localparam int way_bits = 2;

  // victim buffer entries
  localparam int vb_depth = 4;

endpackage

//--- compile.f
cache_pkg.sv
tag_match.sv
plru_tree.sv
cache_mem.sv
victim_buffer.sv
dcache_top.sv
tb_dcache.sv

//--- dcache_top.sv
// data store top joining the line array and the victim buffer
module dcache_top import cache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd_en,
  input  logic [addr_bits-1:0] rd_addr,
  input  logic                 wr_en,
  input  logic [addr_bits-1:0] wr_addr,
  input  logic [data_bits-1:0] wr_data,
  input  logic                 wr_dirty,
  output logic                 rd_hit,
  output logic [data_bits-1:0] rd_data,
  output logic                 wr_miss,
  output logic                 wb_valid,
  output logic [addr_bits-1:0] wb_addr,
  output logic [data_bits-1:0] wb_data
);

  logic                 cm_rd_hit;
  logic [data_bits-1:0] cm_rd_data;
  logic                 vb_rd_hit;
  logic [data_bits-1:0] vb_rd_data;
  logic                 evict_valid;
  logic [addr_bits-1:0] evict_addr;
  logic [data_bits-1:0] evict_data;
  logic                 evict_dirty;

  cache_mem u_cache_mem (
    .clock       (clock),
    .reset       (reset),
    .rd_en       (rd_en),
    .rd_set      (rd_addr[set_bits-1:0]),
    .rd_tag      (rd_addr[addr_bits-1:set_bits]),
    .wr_en       (wr_en),
    .wr_set      (wr_addr[set_bits-1:0]),
    .wr_tag      (wr_addr[addr_bits-1:set_bits]),
    .wr_data     (wr_data),
    .wr_dirty    (wr_dirty),
    .cm_rd_hit   (cm_rd_hit),
    .cm_rd_data  (cm_rd_data),
    .wr_miss     (wr_miss),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .evict_data  (evict_data),
    .evict_dirty (evict_dirty)
  );

  // writes invalidate any copy in the buffer
  victim_buffer u_victim_buffer (
    .clock       (clock),
    .reset       (reset),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .inv_en      (wr_en),
    .inv_addr    (wr_addr),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .evict_data  (evict_data),
    .evict_dirty (evict_dirty),
    .vb_rd_hit   (vb_rd_hit),
    .vb_rd_data  (vb_rd_data),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

  // array result first, buffer second
  assign rd_hit = cm_rd_hit || vb_rd_hit;
  assign rd_data = cm_rd_hit ? cm_rd_data : (vb_rd_hit ? vb_rd_data : '0);

endmodule

//--- plru_tree.sv
// tree pseudo-LRU state per set with victim selection and access update
module plru_tree import cache_pkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                rd_touch,
  input  logic [set_bits-1:0] rd_set,
  input  logic [way_bits-1:0] rd_way,
  input  logic                wr_touch,
  input  logic [set_bits-1:0] wr_set,
  input  logic [way_bits-1:0] wr_way,
  input  logic [set_bits-1:0] victim_set,
  output logic [way_bits-1:0] victim_way
);

  // bit 0 is the root, bit 1 the lower pair, bit 2 the upper pair
  logic [num_sets-1:0][num_ways-2:0] tree_bits;
  logic [num_sets-1:0][num_ways-2:0] tree_next;
  logic [num_ways-2:0]               victim_bits;

  // point every bit on the path away from the touched way
  function automatic logic [num_ways-2:0] touch(
    input logic [num_ways-2:0] bits,
    input logic [way_bits-1:0] way
  );
    logic [num_ways-2:0] result;
    result = bits;
    result[0] = ~way[1];
    if (way[1]) begin
      result[2] = ~way[0];
    end else begin
      result[1] = ~way[0];
    end
    return result;
  endfunction

  // follow the bits down from the root
  assign victim_bits = tree_bits[victim_set];
  assign victim_way = victim_bits[0] ? {1'b1, victim_bits[2]} : {1'b0, victim_bits[1]};

  // read applied last so it wins on a shared bit
  always_comb begin
    tree_next = tree_bits;
    if (wr_touch) begin
      tree_next[wr_set] = touch(tree_next[wr_set], wr_way);
    end
    if (rd_touch) begin
      tree_next[rd_set] = touch(tree_next[rd_set], rd_way);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tree_bits <= '0;
    end else begin
      tree_bits <= tree_next;
    end
  end

endmodule

//--- tag_match.sv
// parallel tag compare over the ways of one set with one-hot to index encoding
module tag_match import cache_pkg::*; (
  input  logic [num_ways-1:0][tag_bits-1:0] way_tags,
  input  logic [num_ways-1:0]               way_valid,
  input  logic [tag_bits-1:0]               tag,
  output logic                              hit,
  output logic [way_bits-1:0]               way
);

  logic [num_ways-1:0] match;

  // one comparator per way
  always_comb begin
    for (int i = 0; i < num_ways; i++) begin
      match[i] = way_valid[i] && (way_tags[i] == tag);
    end
  end

  // at most one way matches, so OR of the indices is the index
  always_comb begin
    hit = |match;
    way = '0;
    for (int i = 0; i < num_ways; i++) begin
      if (match[i]) begin
        way = way | way_bits'(i);
      end
    end
  end

endmodule

//--- tb_dcache.sv
// testbench for the data cache store with stimulus table, clock, reset, checks and timeout
module tb_dcache import cache_pkg::*; ();

  localparam int clock_period = 40;
  localparam int reset_cycles = 4;
  localparam int max_rows = 64;

  logic                 clock;
  logic                 reset;
  logic                 rd_en;
  logic [addr_bits-1:0] rd_addr;
  logic                 wr_en;
  logic [addr_bits-1:0] wr_addr;
  logic [data_bits-1:0] wr_data;
  logic                 wr_dirty;
  logic                 rd_hit;
  logic [data_bits-1:0] rd_data;
  logic                 wr_miss;
  logic                 wb_valid;
  logic [addr_bits-1:0] wb_addr;
  logic [data_bits-1:0] wb_data;

  // one entry per row, stimulus then expected values
  logic                 row_rd_en [max_rows];
  logic [addr_bits-1:0] row_rd_addr [max_rows];
  logic                 row_wr_en [max_rows];
  logic [addr_bits-1:0] row_wr_addr [max_rows];
  logic [data_bits-1:0] row_wr_data [max_rows];
  logic                 row_wr_dirty [max_rows];
  logic                 row_hit [max_rows];
  logic [data_bits-1:0] row_data [max_rows];
  logic                 row_miss [max_rows];
  logic                 row_wb [max_rows];
  logic [addr_bits-1:0] row_wb_addr [max_rows];
  logic [data_bits-1:0] row_wb_data [max_rows];

  int n_rows;
  int cycle_count;
  int max_cycles;

  dcache_top u_dcache_top (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_dirty (wr_dirty),
    .rd_hit   (rd_hit),
    .rd_data  (rd_data),
    .wr_miss  (wr_miss),
    .wb_valid (wb_valid),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(clock_period / 2) clock = ~clock;
    end
  end

  // line address, tag above set
  function automatic logic [addr_bits-1:0] addr_of(input int tag_num, input int set_num);
    return {tag_num[tag_bits-1:0], set_num[set_bits-1:0]};
  endfunction

  function automatic logic [data_bits-1:0] data_of(input int key);
    logic [15:0] part;
    part = key[15:0];
    return {4{part}} ^ 64'h0123_4567_89ab_cdef;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [data_bits-1:0] expected,
                             input logic [data_bits-1:0] actual);
    assert (actual === expected) else begin
      abort_run($sformatf("ERR time %0t %s expected %0h actual %0h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic add_row(input logic r_en, input logic [addr_bits-1:0] r_addr,
                         input logic w_en, input logic [addr_bits-1:0] w_addr,
                         input logic [data_bits-1:0] w_data, input logic w_dirty,
                         input logic e_hit, input logic [data_bits-1:0] e_data,
                         input logic e_miss, input logic e_wb,
                         input logic [addr_bits-1:0] e_wb_addr,
                         input logic [data_bits-1:0] e_wb_data);
    row_rd_en[n_rows] = r_en;
    row_rd_addr[n_rows] = r_addr;
    row_wr_en[n_rows] = w_en;
    row_wr_addr[n_rows] = w_addr;
    row_wr_data[n_rows] = w_data;
    row_wr_dirty[n_rows] = w_dirty;
    row_hit[n_rows] = e_hit;
    row_data[n_rows] = e_data;
    row_miss[n_rows] = e_miss;
    row_wb[n_rows] = e_wb;
    row_wb_addr[n_rows] = e_wb_addr;
    row_wb_data[n_rows] = e_wb_data;
    n_rows++;
  endtask

  task automatic build_table();
    // empty after reset, then basic fill and rewrite in set 2
    add_row(1, addr_of(1, 2), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, addr_of(1023, 7), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(1, 2), data_of(1), 0, 0, 0, 1, 0, 0, 0);
    add_row(1, addr_of(1, 2), 0, 0, 0, 0, 1, data_of(1), 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(1, 2), data_of(2), 1, 0, 0, 0, 0, 0, 0);
    add_row(1, addr_of(1, 2), 0, 0, 0, 0, 1, data_of(2), 0, 0, 0, 0);
    // same line forwards, other tag in the set reads the array
    add_row(1, addr_of(2, 2), 1, addr_of(2, 2), data_of(3), 0, 1, data_of(3), 1, 0, 0, 0);
    add_row(1, addr_of(1, 2), 1, addr_of(4, 2), data_of(4), 0, 1, data_of(2), 1, 0, 0, 0);
    add_row(1, addr_of(4, 2), 0, 0, 0, 0, 1, data_of(4), 0, 0, 0, 0);
    add_row(1, addr_of(2, 2), 0, 0, 0, 0, 1, data_of(3), 0, 0, 0, 0);
    // set 0 fills ways 0, 2, 3, 1 with reads steering the tree
    add_row(0, 0, 1, addr_of(10, 0), data_of(10), 1, 0, 0, 1, 0, 0, 0);
    add_row(0, 0, 1, addr_of(11, 0), data_of(11), 1, 0, 0, 1, 0, 0, 0);
    add_row(1, addr_of(10, 0), 0, 0, 0, 0, 1, data_of(10), 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(12, 0), data_of(12), 0, 0, 0, 1, 0, 0, 0);
    add_row(0, 0, 1, addr_of(13, 0), data_of(13), 1, 0, 0, 1, 0, 0, 0);
    add_row(1, addr_of(11, 0), 0, 0, 0, 0, 1, data_of(11), 0, 0, 0, 0);
    // way 0 goes to the victim buffer and still hits there
    add_row(0, 0, 1, addr_of(14, 0), data_of(14), 0, 0, 0, 1, 0, 0, 0);
    add_row(1, addr_of(10, 0), 0, 0, 0, 0, 1, data_of(10), 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(15, 0), data_of(15), 0, 0, 0, 1, 0, 0, 0);
    add_row(0, 0, 1, addr_of(16, 0), data_of(16), 0, 0, 0, 1, 0, 0, 0);
    add_row(0, 0, 1, addr_of(17, 0), data_of(17), 0, 0, 0, 1, 0, 0, 0);
    // buffer full: dirty, clean, dirty oldest entries
    add_row(0, 0, 1, addr_of(18, 0), data_of(18), 0, 0, 0, 1, 1, addr_of(10, 0), data_of(10));
    add_row(0, 0, 1, addr_of(19, 0), data_of(19), 0, 0, 0, 1, 0, 0, 0);
    add_row(0, 0, 1, addr_of(20, 0), data_of(20), 0, 0, 0, 1, 1, addr_of(13, 0), data_of(13));
    // rewrite of a buffered line frees its slot
    add_row(1, addr_of(14, 0), 0, 0, 0, 0, 1, data_of(14), 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(14, 0), data_of(40), 1, 0, 0, 1, 0, 0, 0);
    add_row(1, addr_of(14, 0), 0, 0, 0, 0, 1, data_of(40), 0, 0, 0, 0);
    add_row(1, addr_of(17, 0), 0, 0, 0, 0, 1, data_of(17), 0, 0, 0, 0);
    add_row(0, 0, 1, addr_of(21, 0), data_of(21), 0, 0, 0, 1, 1, addr_of(11, 0), data_of(11));
    add_row(1, addr_of(11, 0), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      abort_run($sformatf("timeout, no end of the table after %0d cycles", max_cycles));
    end
  end

  initial begin
    reset = 1'b1;
    rd_en = 1'b0;
    rd_addr = '0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_dirty = 1'b0;
    cycle_count = 0;
    n_rows = 0;
    build_table();
    max_cycles = n_rows + reset_cycles + 10;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      rd_en = row_rd_en[i];
      rd_addr = row_rd_addr[i];
      wr_en = row_wr_en[i];
      wr_addr = row_wr_addr[i];
      wr_data = row_wr_data[i];
      wr_dirty = row_wr_dirty[i];
      // sample just ahead of the rising edge
      #(clock_period / 2 - 1);
      check_value("rd_hit", row_hit[i], rd_hit);
      check_value("rd_data", row_data[i], rd_data);
      check_value("wr_miss", row_miss[i], wr_miss);
      // write-back of the previous row shows up in this cycle
      if (i == 0) begin
        check_value("wb_valid", 0, wb_valid);
      end else begin
        check_value("wb_valid", row_wb[i-1], wb_valid);
        if (row_wb[i-1]) begin
          check_value("wb_addr", row_wb_addr[i-1], wb_addr);
          check_value("wb_data", row_wb_data[i-1], wb_data);
        end
      end
      @(negedge clock);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- victim_buffer.sv
// fully associative buffer of evicted lines with read lookup and dirty write-back
module victim_buffer import cache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd_en,
  input  logic [addr_bits-1:0] rd_addr,
  input  logic                 inv_en,
  input  logic [addr_bits-1:0] inv_addr,
  input  logic                 evict_valid,
  input  logic [addr_bits-1:0] evict_addr,
  input  logic [data_bits-1:0] evict_data,
  input  logic                 evict_dirty,
  output logic                 vb_rd_hit,
  output logic [data_bits-1:0] vb_rd_data,
  output logic                 wb_valid,
  output logic [addr_bits-1:0] wb_addr,
  output logic [data_bits-1:0] wb_data
);

  // entries kept packed at the bottom, slot 0 is the oldest
  logic [vb_depth-1:0]  vb_valid;
  logic [vb_depth-1:0]  vb_dirty;
  logic [addr_bits-1:0] vb_addr [vb_depth];
  logic [data_bits-1:0] vb_data [vb_depth];

  logic [vb_depth-1:0]  inv_match;
  logic [vb_depth-1:0]  s1_valid;
  logic [vb_depth-1:0]  s1_dirty;
  logic [addr_bits-1:0] s1_addr [vb_depth];
  logic [data_bits-1:0] s1_data [vb_depth];

  logic [vb_depth-1:0]  n_valid;
  logic [vb_depth-1:0]  n_dirty;
  logic [addr_bits-1:0] n_addr [vb_depth];
  logic [data_bits-1:0] n_data [vb_depth];

  logic full;
  logic wb_take;

  always_comb begin
    vb_rd_hit = 1'b0;
    vb_rd_data = '0;
    for (int i = 0; i < vb_depth; i++) begin
      inv_match[i] = inv_en && vb_valid[i] && (vb_addr[i] == inv_addr);
      if (rd_en && vb_valid[i] && (vb_addr[i] == rd_addr)) begin
        vb_rd_hit = 1'b1;
        vb_rd_data = vb_data[i];
      end
    end
  end

  // drop the invalidated entry, closing the gap above it
  always_comb begin
    logic gone;
    gone = 1'b0;
    for (int i = 0; i < vb_depth - 1; i++) begin
      gone = gone | inv_match[i];
      s1_valid[i] = gone ? vb_valid[i+1] : vb_valid[i];
      s1_dirty[i] = gone ? vb_dirty[i+1] : vb_dirty[i];
      s1_addr[i] = gone ? vb_addr[i+1] : vb_addr[i];
      s1_data[i] = gone ? vb_data[i+1] : vb_data[i];
    end
    gone = gone | inv_match[vb_depth-1];
    s1_valid[vb_depth-1] = vb_valid[vb_depth-1] && !gone;
    s1_dirty[vb_depth-1] = vb_dirty[vb_depth-1];
    s1_addr[vb_depth-1] = vb_addr[vb_depth-1];
    s1_data[vb_depth-1] = vb_data[vb_depth-1];
  end

  // full once invalidation has had its chance to free a slot
  assign full = s1_valid[vb_depth-1];
  assign wb_take = evict_valid && full && s1_dirty[0];

  always_comb begin
    logic placed;
    placed = 1'b0;
    n_valid = s1_valid;
    n_dirty = s1_dirty;
    n_addr = s1_addr;
    n_data = s1_data;
    if (evict_valid && full) begin
      // oldest falls out, new line goes on top
      for (int i = 0; i < vb_depth - 1; i++) begin
        n_dirty[i] = s1_dirty[i+1];
        n_addr[i] = s1_addr[i+1];
        n_data[i] = s1_data[i+1];
      end
      n_dirty[vb_depth-1] = evict_dirty;
      n_addr[vb_depth-1] = evict_addr;
      n_data[vb_depth-1] = evict_data;
    end else if (evict_valid) begin
      for (int i = 0; i < vb_depth; i++) begin
        if (!s1_valid[i] && !placed) begin
          n_valid[i] = 1'b1;
          n_dirty[i] = evict_dirty;
          n_addr[i] = evict_addr;
          n_data[i] = evict_data;
          placed = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      vb_valid <= '0;
      wb_valid <= 1'b0;
    end else begin
      vb_valid <= n_valid;
      wb_valid <= wb_take;
    end
  end

  always_ff @(posedge clock) begin
    vb_dirty <= n_dirty;
    vb_addr <= n_addr;
    vb_data <= n_data;
    if (wb_take) begin
      wb_addr <= s1_addr[0];
      wb_data <= s1_data[0];
    end
  end

endmodule
